// File: hw/cabIo.sv
`timescale 1ns/1ns

module cabIo
(
	input  logic                                mclk,
	input  logic                                arstN,
	input  logic [neoIoPkg::DIP_W-1:0]          dipSw,		// Active low
	input  logic                                wrStrobe,
	input  logic [2:0]                          wrSel,
	input  neoIoPkg::ioWrByte                   wrByte,
	output logic [neoIoPkg::DIP_W-1:0]          dipSync,
	output logic [neoIoPkg::LED_W-1:0]          led1Out,	// Active low lamps
	output logic [neoIoPkg::LED_W-1:0]          led2Out,
	output logic [neoIoPkg::EL_W-1:0]           elOut
);

	logic [neoIoPkg::DIP_W-1:0] dipMeta;
	logic                       led1Wr;
	logic                       led2Wr;
	logic                       elWr;

	// DIP switches move slowly but still come in async
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			dipMeta <= '1;		// All switches off
			dipSync <= '1;
		end
		else
		begin
			dipMeta <= dipSw;
			dipSync <= dipMeta;
		end
	end

	// One decode per latch
	assign led1Wr = wrStrobe & (wrSel == neoIoPkg::SEL_LED1);
	assign led2Wr = wrStrobe & (wrSel == neoIoPkg::SEL_LED2);
	assign elWr   = wrStrobe & (wrSel == neoIoPkg::SEL_EL);

	// LED bank 1
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
			led1Out <= neoIoPkg::LAMP_IDLE;
		else if (led1Wr)
			led1Out <= wrByte.lampView;
	end

	// LED bank 2
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
			led2Out <= neoIoPkg::LAMP_IDLE;
		else if (led2Wr)
			led2Out <= wrByte.lampView;
	end

	// EL lamps, low nibble of the pattern
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
			elOut <= neoIoPkg::LAMP_IDLE[neoIoPkg::EL_W-1:0];
		else if (elWr)
			elOut <= wrByte.lampView[neoIoPkg::EL_W-1:0];
	end

endmodule

// File: hw/ioBusIf.sv
`timescale 1ns/1ns

module ioBusIf
(
	input  logic                                mclk,
	input  logic                                arstN,
	input  logic [23:1]                         addr,
	input  logic [15:0]                         dataIn,
	input  logic                                rw,		// High = read
	input  logic                                asN,
	input  logic                                udsN,
	input  logic                                ldsN,
	input  logic [neoIoPkg::PLAYER_W-1:0]       p1Sync,
	input  logic [neoIoPkg::PLAYER_W-1:0]       p2Sync,
	input  logic                                testSync,
	input  logic [neoIoPkg::DIP_W-1:0]          dipSync,
	output logic [15:0]                         dataOut,
	output logic                                dataOe,
	output logic                                wrStrobe,
	output logic [2:0]                          wrSel,
	output neoIoPkg::ioWrByte                   wrByte
);

	logic        asS;			// asN at last edge
	logic        asD;			// One edge older
	logic        accStart;		// High for one cycle per access
	logic [7:0]  zone;
	logic        hitCtrl1;
	logic        hitCtrl2;
	logic        hitStatB;
	logic        rdHit;
	logic        wrHit;
	logic [7:0]  statB;
	logic [15:0] rdWord;

	// Strobe history, idle high
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			asS <= 1'b1;
			asD <= 1'b1;
		end
		else
		begin
			asS <= asN;
			asD <= asS;
		end
	end

	// Falling edge seen on the previous clock
	assign accStart = asD & ~asS & ~asN;

	// Mirrors below bit 16 fall into the same zone
	assign zone     = addr[23:16];
	assign hitCtrl1 = (zone == neoIoPkg::ZONE_CTRL1);
	assign hitCtrl2 = (zone == neoIoPkg::ZONE_CTRL2);
	assign hitStatB = (zone == neoIoPkg::ZONE_STATUSB);

	// A read needs at least one data strobe, as on the 68000
	assign rdHit = rw & (hitCtrl1 | hitCtrl2 | hitStatB) & ~(udsN & ldsN);
	// Latches sit on the low byte lane only
	assign wrHit = ~rw & hitStatB & ~ldsN;

	// Status B upper byte
	assign statB = {
		testSync,						// Bit 7
		3'b111,							// Unused, read as ones
		p2Sync[neoIoPkg::SELECT_BIT],
		p2Sync[neoIoPkg::START_BIT],
		p1Sync[neoIoPkg::SELECT_BIT],
		p1Sync[neoIoPkg::START_BIT]		// Bit 0
	};

	always_comb
	begin
		rdWord = 16'hFFFF;
		if (hitCtrl1)
			rdWord = {p1Sync[7:0], dipSync};
		else if (hitCtrl2)
			rdWord = {p2Sync[7:0], 8'hFF};
		else if (hitStatB)
			rdWord = {statB, 8'hFF};
	end

	// Response word held for the rest of the access
	always_ff @(posedge mclk)
	begin
		if (accStart && rdHit)
			dataOut <= rdWord;
	end

	// Enable drops on the first edge that sees asN high
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
			dataOe <= 1'b0;
		else if (asN)
			dataOe <= 1'b0;
		else if (accStart && rdHit)
			dataOe <= 1'b1;
	end

	// Single cycle write pulse
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
			wrStrobe <= 1'b0;
		else
			wrStrobe <= accStart & wrHit;
	end

	// Select and byte ride alongside the pulse
	always_ff @(posedge mclk)
	begin
		if (accStart && wrHit)
		begin
			wrSel  <= addr[6:4];
			wrByte <= dataIn[7:0];
		end
	end

endmodule

// File: hw/joyPort.sv
`timescale 1ns/1ns

module joyPort
(
	input  logic                                mclk,
	input  logic                                arstN,
	input  logic [neoIoPkg::PLAYER_W-1:0]       p1In,		// Active low
	input  logic [neoIoPkg::PLAYER_W-1:0]       p2In,
	input  logic                                testN,
	input  logic                                wrStrobe,
	input  logic [2:0]                          wrSel,
	input  neoIoPkg::ioWrByte                   wrByte,
	output logic [neoIoPkg::PLAYER_W-1:0]       p1Sync,
	output logic [neoIoPkg::PLAYER_W-1:0]       p2Sync,
	output logic                                testSync,
	output logic [neoIoPkg::JOYOUT_W-1:0]       p1Out,
	output logic [neoIoPkg::JOYOUT_W-1:0]       p2Out
);

	logic [neoIoPkg::PLAYER_W-1:0] p1Meta;	// First stage
	logic [neoIoPkg::PLAYER_W-1:0] p2Meta;
	logic                          testMeta;
	logic                          joyWr;

	// Two-flop sync, idle is released (high)
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			p1Meta   <= '1;
			p2Meta   <= '1;
			testMeta <= 1'b1;
			p1Sync   <= '1;
			p2Sync   <= '1;
			testSync <= 1'b1;
		end
		else
		begin
			p1Meta   <= p1In;
			p2Meta   <= p2In;
			testMeta <= testN;
			p1Sync   <= p1Meta;
			p2Sync   <= p2Meta;
			testSync <= testMeta;
		end
	end

	assign joyWr = wrStrobe & (wrSel == neoIoPkg::SEL_JOYOUT);

	// Joypad output pins, both ports in one byte
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			p1Out <= neoIoPkg::JOYOUT_IDLE;
			p2Out <= neoIoPkg::JOYOUT_IDLE;
		end
		else if (joyWr)
		begin
			p1Out <= wrByte.joyView.p1Out;		// Bits 2:0
			p2Out <= wrByte.joyView.p2Out;		// Bits 5:3
		end
	end

endmodule

// File: hw/neoIo.sv
`timescale 1ns/1ns

module neoIo
(
	input  logic                                mclk,
	input  logic                                arstN,
	input  logic [23:1]                         addr,
	input  logic [15:0]                         dataIn,
	input  logic                                rw,
	input  logic                                asN,
	input  logic                                udsN,
	input  logic                                ldsN,
	input  logic [neoIoPkg::PLAYER_W-1:0]       p1In,
	input  logic [neoIoPkg::PLAYER_W-1:0]       p2In,
	input  logic                                testN,
	input  logic [neoIoPkg::DIP_W-1:0]          dipSw,
	output logic [15:0]                         dataOut,
	output logic                                dataOe,
	output logic [neoIoPkg::JOYOUT_W-1:0]       p1Out,
	output logic [neoIoPkg::JOYOUT_W-1:0]       p2Out,
	output logic [neoIoPkg::LED_W-1:0]          led1Out,
	output logic [neoIoPkg::LED_W-1:0]          led2Out,
	output logic [neoIoPkg::EL_W-1:0]           elOut
);

	logic [neoIoPkg::PLAYER_W-1:0] p1Sync;
	logic [neoIoPkg::PLAYER_W-1:0] p2Sync;
	logic                          testSync;
	logic [neoIoPkg::DIP_W-1:0]    dipSync;
	logic                          wrStrobe;	// Output zone write pulse
	logic [2:0]                    wrSel;
	neoIoPkg::ioWrByte             wrByte;

	// 68k side
	ioBusIf busIf (
		.mclk     (mclk),
		.arstN    (arstN),
		.addr     (addr),
		.dataIn   (dataIn),
		.rw       (rw),
		.asN      (asN),
		.udsN     (udsN),
		.ldsN     (ldsN),
		.p1Sync   (p1Sync),
		.p2Sync   (p2Sync),
		.testSync (testSync),
		.dipSync  (dipSync),
		.dataOut  (dataOut),
		.dataOe   (dataOe),
		.wrStrobe (wrStrobe),
		.wrSel    (wrSel),
		.wrByte   (wrByte)
	);

	// Joypads and test button
	joyPort joy (
		.mclk     (mclk),
		.arstN    (arstN),
		.p1In     (p1In),
		.p2In     (p2In),
		.testN    (testN),
		.wrStrobe (wrStrobe),
		.wrSel    (wrSel),
		.wrByte   (wrByte),
		.p1Sync   (p1Sync),
		.p2Sync   (p2Sync),
		.testSync (testSync),
		.p1Out    (p1Out),
		.p2Out    (p2Out)
	);

	// Cabinet DIPs and lamps
	cabIo cab (
		.mclk     (mclk),
		.arstN    (arstN),
		.dipSw    (dipSw),
		.wrStrobe (wrStrobe),
		.wrSel    (wrSel),
		.wrByte   (wrByte),
		.dipSync  (dipSync),
		.led1Out  (led1Out),
		.led2Out  (led2Out),
		.elOut    (elOut)
	);

endmodule

// File: hw/neoIoPkg.sv
package neoIoPkg;

	// Zone bases, matched against addr[23:16]
	localparam logic [7:0] ZONE_CTRL1   = 8'h30;	// P1 + DIP
	localparam logic [7:0] ZONE_CTRL2   = 8'h34;	// P2
	localparam logic [7:0] ZONE_STATUSB = 8'h38;	// Status B read, latches on write

	// Output latch selects, addr[6:4] in the status B zone
	localparam logic [2:0] SEL_JOYOUT = 3'd0;
	localparam logic [2:0] SEL_LED1   = 3'd1;
	localparam logic [2:0] SEL_LED2   = 3'd2;
	localparam logic [2:0] SEL_EL     = 3'd3;

	// Player bus layout
	localparam int PLAYER_W   = 10;	// Directions/buttons in [7:0]
	localparam int START_BIT  = 8;
	localparam int SELECT_BIT = 9;

	localparam int JOYOUT_W = 3;
	localparam int LED_W    = 8;
	localparam int EL_W     = 4;
	localparam int DIP_W    = 8;

	// Lamps are active low, so idle is all ones
	localparam logic [LED_W-1:0]    LAMP_IDLE   = '1;
	localparam logic [JOYOUT_W-1:0] JOYOUT_IDLE = '0;

	// Byte written to the output zone
	// Joypad select reads it as two pin groups, lamp selects as a pattern
	typedef union packed
	{
		struct packed
		{
			logic [1:0]          unused;	// Bits 7:6, no pins behind them
			logic [JOYOUT_W-1:0] p2Out;
			logic [JOYOUT_W-1:0] p1Out;
		} joyView;
		logic [7:0] lampView;
	} ioWrByte;

endpackage

// File: tb/neoIoTb.sv
`timescale 1ns/1ns

module neoIoTb;

	localparam int PERIOD          = 20;
	localparam int RESET_CYCLES    = 8;
	localparam int DIRECT_ACCESSES = 64;	// Upper bound over tests 2 to 5
	localparam int RANDOM_ACCESSES = 200;
	localparam int ACCESS_CYCLES   = 12;
	localparam int TIMEOUT_NS      =
		((DIRECT_ACCESSES + RANDOM_ACCESSES) * ACCESS_CYCLES + RESET_CYCLES + 4) * PERIOD;

	logic                                mclk;
	logic                                arstN;
	logic [23:1]                         addr;
	logic [15:0]                         dataIn;
	logic                                rw;
	logic                                asN;
	logic                                udsN;
	logic                                ldsN;
	logic [neoIoPkg::PLAYER_W-1:0]       p1In;
	logic [neoIoPkg::PLAYER_W-1:0]       p2In;
	logic                                testN;
	logic [neoIoPkg::DIP_W-1:0]          dipSw;
	logic [15:0]                         dataOut;
	logic                                dataOe;
	logic [neoIoPkg::JOYOUT_W-1:0]       p1Out;
	logic [neoIoPkg::JOYOUT_W-1:0]       p2Out;
	logic [neoIoPkg::LED_W-1:0]          led1Out;
	logic [neoIoPkg::LED_W-1:0]          led2Out;
	logic [neoIoPkg::EL_W-1:0]           elOut;

	// Testbench copies of the board inputs
	logic [neoIoPkg::PLAYER_W-1:0] p1Val;
	logic [neoIoPkg::PLAYER_W-1:0] p2Val;
	logic                          testVal;
	logic [neoIoPkg::DIP_W-1:0]    dipVal;

	// Shadow latches
	logic [neoIoPkg::JOYOUT_W-1:0] shP1;
	logic [neoIoPkg::JOYOUT_W-1:0] shP2;
	logic [neoIoPkg::LED_W-1:0]    shLed1;
	logic [neoIoPkg::LED_W-1:0]    shLed2;
	logic [neoIoPkg::EL_W-1:0]     shEl;

	logic [31:0] rngState;
	string       testName;

	// Handed from the bus tasks to the compare process
	event        accDone;
	logic        cmpIsRead;
	string       cmpName;
	logic [15:0] rdWordSeen;
	logic        rdOeSeen;
	logic        oeEarly;		// One edge before the expected enable
	logic        oeAfter;		// First edge after asN release
	logic [15:0] expWord;
	logic        expOe;

	neoIo uut (
		.mclk    (mclk),
		.arstN   (arstN),
		.addr    (addr),
		.dataIn  (dataIn),
		.rw      (rw),
		.asN     (asN),
		.udsN    (udsN),
		.ldsN    (ldsN),
		.p1In    (p1In),
		.p2In    (p2In),
		.testN   (testN),
		.dipSw   (dipSw),
		.dataOut (dataOut),
		.dataOe  (dataOe),
		.p1Out   (p1Out),
		.p2Out   (p2Out),
		.led1Out (led1Out),
		.led2Out (led2Out),
		.elOut   (elOut)
	);

	initial
	begin
		mclk = 1'b0;
		forever #(PERIOD/2) mclk = ~mclk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic drawRandom(output logic [31:0] r);
		rngState = xorshift32(rngState);
		r = rngState;
	endtask

	// Expected {enable, word} of a read
	function automatic logic [16:0] expectRead(input logic [23:1] a);
		logic [15:0] w;
		logic        e;
		e = 1'b1;
		if (a[23:16] == neoIoPkg::ZONE_CTRL1)
			w = {p1Val[7:0], dipVal};
		else if (a[23:16] == neoIoPkg::ZONE_CTRL2)
			w = {p2Val[7:0], 8'hFF};
		else if (a[23:16] == neoIoPkg::ZONE_STATUSB)
			w = {testVal, 3'b111, p2Val[9], p2Val[8], p1Val[9], p1Val[8], 8'hFF};
		else
		begin
			e = 1'b0;		// Unmapped address leaves the bus alone
			w = 16'hFFFF;
		end
		return {e, w};
	endfunction

	// Shadow update for one write
	task automatic applyWrite(input logic [23:1] a, input logic [7:0] b, input logic lds);
		if (!lds && a[23:16] == neoIoPkg::ZONE_STATUSB)
		begin
			case (a[6:4])
				3'd0:
				begin
					shP1 = b[2:0];
					shP2 = b[5:3];
				end
				3'd1:    shLed1 = b;
				3'd2:    shLed2 = b;
				3'd3:    shEl = b[3:0];
				default: ;		// Unused selects
			endcase
		end
	endtask

	// Index 3 picks an unmapped zone byte
	function automatic logic [23:1] zoneAddr(input logic [1:0] k, input logic [31:0] rnd);
		logic [23:1] a;
		logic [7:0]  z;
		z = rnd[31:24];
		if (z == neoIoPkg::ZONE_CTRL1 || z == neoIoPkg::ZONE_CTRL2 || z == neoIoPkg::ZONE_STATUSB)
			z = z ^ 8'h01;
		case (k)
			2'd0:    z = neoIoPkg::ZONE_CTRL1;
			2'd1:    z = neoIoPkg::ZONE_CTRL2;
			2'd2:    z = neoIoPkg::ZONE_STATUSB;
			default: ;
		endcase
		a = {z, rnd[14:0]};		// Low bits are mirrors
		return a;
	endfunction

	function automatic logic [23:1] statusAddr(input logic [2:0] sel, input logic [31:0] rnd);
		logic [23:1] a;
		a = {neoIoPkg::ZONE_STATUSB, rnd[14:0]};
		a[6:4] = sel;
		return a;
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	task automatic checkWord(input string name, input logic [15:0] expW, input logic expE,
		input logic [15:0] actW, input logic actE);
		if (actE !== expE)
			failRun($sformatf("FAILED %s dataOe expected %0b actual %0b", name, expE, actE));
		else if (expE && actW !== expW)
			failRun($sformatf("FAILED %s dataOut expected %h actual %h", name, expW, actW));
	endtask

	task automatic checkJoyOut(input string name, input logic [neoIoPkg::JOYOUT_W-1:0] expV,
		input logic [neoIoPkg::JOYOUT_W-1:0] actV);
		if (actV !== expV)
			failRun($sformatf("FAILED %s expected %h actual %h", name, expV, actV));
	endtask

	task automatic checkLamp(input string name, input logic [neoIoPkg::LED_W-1:0] expV,
		input logic [neoIoPkg::LED_W-1:0] actV);
		if (actV !== expV)
			failRun($sformatf("FAILED %s expected %h actual %h", name, expV, actV));
	endtask

	// Drive board inputs, then let them through the synchronizers
	task automatic setInputs(input logic [9:0] p1, input logic [9:0] p2, input logic t,
		input logic [7:0] dip);
		@(posedge mclk);
		#2;
		p1In    = p1;
		p2In    = p2;
		testN   = t;
		dipSw   = dip;
		p1Val   = p1;
		p2Val   = p2;
		testVal = t;
		dipVal  = dip;
		repeat (4) @(posedge mclk);
	endtask

	task automatic busRead(input logic [23:1] a);
		@(posedge mclk);
		#2;
		addr = a;
		rw   = 1'b1;
		udsN = 1'b0;
		ldsN = 1'b0;
		asN  = 1'b0;
		@(posedge mclk);		// Access edge
		#1;
		oeEarly = dataOe;
		@(posedge mclk);		// Response registered
		#1;
		rdWordSeen = dataOut;
		rdOeSeen   = dataOe;
		#1;
		asN  = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		@(posedge mclk);
		#1;
		oeAfter = dataOe;
		{expOe, expWord} = expectRead(a);
		cmpIsRead = 1'b1;
		cmpName   = testName;
		-> accDone;
	endtask

	task automatic busWrite(input logic [23:1] a, input logic [7:0] b, input logic lds,
		input logic [7:0] upper);
		@(posedge mclk);
		#2;
		addr   = a;
		dataIn = {upper, b};
		rw     = 1'b0;
		udsN   = 1'b1;
		ldsN   = lds;
		asN    = 1'b0;
		repeat (3) @(posedge mclk);		// Edge, strobe, latch
		#2;
		asN  = 1'b1;
		ldsN = 1'b1;
		rw   = 1'b1;
		applyWrite(a, b, lds);
		cmpIsRead = 1'b0;
		cmpName   = testName;
		-> accDone;
	endtask

	// Compares each finished access with the reference
	always @(accDone)
	begin
		if (cmpIsRead)
		begin
			checkWord($sformatf("%s early", cmpName), 16'h0000, 1'b0, rdWordSeen, oeEarly);
			checkWord(cmpName, expWord, expOe, rdWordSeen, rdOeSeen);
			checkWord($sformatf("%s release", cmpName), 16'h0000, 1'b0, rdWordSeen, oeAfter);
		end
		else
		begin
			checkJoyOut($sformatf("%s p1Out", cmpName), shP1, p1Out);
			checkJoyOut($sformatf("%s p2Out", cmpName), shP2, p2Out);
			checkLamp($sformatf("%s led1Out", cmpName), shLed1, led1Out);
			checkLamp($sformatf("%s led2Out", cmpName), shLed2, led2Out);
			checkLamp($sformatf("%s elOut", cmpName),
				{{(neoIoPkg::LED_W-neoIoPkg::EL_W){1'b0}}, shEl},
				{{(neoIoPkg::LED_W-neoIoPkg::EL_W){1'b0}}, elOut});
			checkWord($sformatf("%s dataOe", cmpName), 16'h0000, 1'b0, dataOut, dataOe);
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		failRun("Watchdog expired, a bus access never completed");
	end

	initial
	begin
		logic [31:0] r;
		logic [31:0] r2;
		logic [16:0] baseExp;
		int          i;
		int          k;
		rngState = 32'h70e6c4ee;
		arstN    = 1'b0;
		addr     = '0;
		dataIn   = '0;
		rw       = 1'b1;
		asN      = 1'b1;
		udsN     = 1'b1;
		ldsN     = 1'b1;
		p1In     = '1;		// Nothing pressed
		p2In     = '1;
		testN    = 1'b1;
		dipSw    = '1;
		p1Val    = '1;
		p2Val    = '1;
		testVal  = 1'b1;
		dipVal   = '1;
		shP1     = '0;
		shP2     = '0;
		shLed1   = '1;
		shLed2   = '1;
		shEl     = '1;
		repeat (RESET_CYCLES) @(posedge mclk);
		#2;
		arstN = 1'b1;

		// 1 Idle outputs after reset
		testName = "reset";
		@(posedge mclk);
		#1;
		cmpIsRead = 1'b0;
		cmpName   = testName;
		-> accDone;

		// 2 CTRL1 word and enable timing
		testName = "ctrl1";
		for (i = 0; i < 8; i++)
		begin
			drawRandom(r);
			setInputs(r[9:0], p2Val, testVal, r[17:10]);
			drawRandom(r);
			busRead(zoneAddr(2'd0, r));
		end

		// 3 CTRL2 and status B packing
		testName = "ctrl2 statusb";
		for (i = 0; i < 8; i++)
		begin
			drawRandom(r);
			setInputs(r[9:0], r[19:10], r[20], r[28:21]);
			drawRandom(r);
			busRead(zoneAddr(2'd1, r));
			busRead(zoneAddr(2'd2, r));
		end

		// 4 Latch writes, one select at a time
		testName = "latch write";
		for (k = 0; k < 4; k++)
		begin
			for (i = 0; i < 4; i++)
			begin
				drawRandom(r);
				busWrite(statusAddr(k[2:0], r), r[23:16], 1'b0, r[31:24]);
			end
		end
		testName = "unused select";
		for (k = 4; k < 8; k++)
		begin
			drawRandom(r);
			busWrite(statusAddr(k[2:0], r), r[23:16], 1'b0, r[31:24]);
		end
		testName = "ldsN high";
		for (k = 0; k < 4; k++)
		begin
			drawRandom(r);
			busWrite(statusAddr(k[2:0], r), r[23:16], 1'b1, r[31:24]);
		end

		// 5 Unmapped and mirrored reads
		testName = "unmapped";
		for (i = 0; i < 4; i++)
		begin
			drawRandom(r);
			busRead(zoneAddr(2'd3, r));
		end
		testName = "mirror";
		for (k = 0; k < 3; k++)
		begin
			for (i = 0; i < 2; i++)
			begin
				drawRandom(r);
				busRead(zoneAddr(k[1:0], 32'h0));		// Zone base
				busRead(zoneAddr(k[1:0], r));
				// Mirror word against the base address reference
				baseExp = expectRead(zoneAddr(k[1:0], 32'h0));
				checkWord("mirror vs base", baseExp[15:0], baseExp[16], rdWordSeen, rdOeSeen);
			end
		end

		// 6 Mixed random traffic
		testName = "random";
		for (i = 0; i < RANDOM_ACCESSES; i++)
		begin
			drawRandom(r);
			drawRandom(r2);
			case (r[1:0])
				2'd0:
				begin
					setInputs(r2[9:0], r2[19:10], r2[20], r2[28:21]);
					busRead(zoneAddr(r[3:2], r));
				end
				2'd1:    busRead(zoneAddr(r[3:2], r2));
				default:
				begin
					if (r[6:4] == 3'd0)		// Now and then a write outside status B
						busWrite(zoneAddr(r[8:7], r2), r2[7:0], 1'b0, r2[15:8]);
					else
						busWrite(statusAddr(r2[2:0], r2), r2[23:16], r[9] & r[10], r2[31:24]);
				end
			endcase
		end

		@(posedge mclk);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: vlog.f
hw/neoIoPkg.sv
hw/ioBusIf.sv
hw/joyPort.sv
hw/cabIo.sv
hw/neoIo.sv
tb/neoIoTb.sv
